/* roce_ack_pkg.sv */
package roce_ack_pkg;

  // payload beat
  localparam int data_width = 512;

  typedef logic [data_width-1:0] word_t;

  // iana port for roce v2
  localparam logic [15:0] roce_udp_port = 16'd4791;

  // rc acknowledge, the only opcode decoded here
  localparam logic [7:0] op_rc_ack = 8'h11;

  // base transport header fields kept by the receiver
  typedef struct packed {
    logic [7:0]  op_code;
    logic [15:0] p_key;
    logic [23:0] dest_qp;
    logic        ack_req;
    logic [23:0] psn;
  } bth_t;

  // ack extended transport header
  typedef struct packed {
    logic [7:0]  syndrome;
    logic [23:0] msn;
  } aeth_t;

  typedef logic [31:0] icrc_t;

  // statistics counter, saturating
  typedef logic [15:0] count_t;

endpackage

/* roce_hdr_queue.sv */
`timescale 1ns/1ps

module roce_hdr_queue #(
  parameter type payload_t = logic,
  // power of two, at least 2
  parameter int depth = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  localparam int ptr_w = $clog2(depth);
  localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic [ptr_w:0]   count_next;
  logic             do_push;
  logic             do_pop;

  assign push_ready = (count != full_count);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;
  assign pop_data   = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + 1'b1;
    end else if (!do_push && do_pop) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
    end else begin
      // pointers wrap on their own since depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count_next;
      pop_valid <= (count_next != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    count == full_count |-> !push_valid);

endmodule

/* roce_rx_stats.sv */
`timescale 1ns/1ps

module roce_rx_stats (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ev_accept,
  input  logic                 ev_not_ack,
  input  logic                 ev_bad_icrc,
  input  logic                 frame_active,
  output logic                 busy,
  output roce_ack_pkg::count_t accept_count,
  output roce_ack_pkg::count_t not_ack_count,
  output roce_ack_pkg::count_t bad_icrc_count
);
  import roce_ack_pkg::*;

  // index 0 accept, 1 not ack, 2 bad icrc
  logic [2:0] ev;
  count_t     cnt [3];

  assign ev = {ev_bad_icrc, ev_not_ack, ev_accept};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      busy <= frame_active;
      for (int i = 0; i < 3; i++) begin
        // hold at all ones
        if (ev[i] && (cnt[i] != '1)) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign accept_count   = cnt[0];
  assign not_ack_count  = cnt[1];
  assign bad_icrc_count = cnt[2];

  // one decision per frame, so never two outcomes at once
  a_one_event: assert property (@(posedge clk) disable iff (rst) $onehot0(ev));

endmodule

/* roce_frame_parser.sv */
`timescale 1ns/1ps

module roce_frame_parser #(
  parameter bit icrc_check_en = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  // udp header channel
  input  logic                hdr_valid,
  output logic                hdr_ready,
  input  logic [15:0]         udp_dest_port,
  input  logic [15:0]         udp_length,
  input  roce_ack_pkg::icrc_t computed_icrc,
  // payload beats
  input  logic                pay_valid,
  output logic                pay_ready,
  input  roce_ack_pkg::word_t pay_data,
  input  logic                pay_last,
  // results towards the queues
  output logic                bth_push_valid,
  input  logic                bth_push_ready,
  output roce_ack_pkg::bth_t  bth_push_data,
  output logic                aeth_push_valid,
  input  logic                aeth_push_ready,
  output roce_ack_pkg::aeth_t aeth_push_data,
  // events for the stats block
  output logic                ev_accept,
  output logic                ev_not_ack,
  output logic                ev_bad_icrc,
  output logic                frame_active
);
  import roce_ack_pkg::*;

  // udp header, bth, aeth and icrc in bytes
  localparam logic [15:0] min_ack_len = 16'd28;

  typedef enum logic [1:0] {
    st_idle,
    st_read_hdr,
    st_check,
    st_drain
  } state_t;

  state_t state;
  state_t state_next;
  logic   hdr_ready_next;
  logic   pay_ready_next;
  logic   store_hdr;
  logic   store_word;
  logic   not_ack;
  logic   bad_icrc;

  // latched header and first beat fields
  logic [15:0] dest_port_reg;
  logic [15:0] length_reg;
  icrc_t       computed_icrc_reg;
  icrc_t       received_icrc_reg;
  bth_t        bth_reg;
  aeth_t       aeth_reg;
  logic        first_last_reg;

  always_comb begin
    state_next     = state;
    hdr_ready_next = 1'b0;
    pay_ready_next = 1'b0;
    store_hdr      = 1'b0;
    store_word     = 1'b0;
    case (state)
      st_idle: begin
        // take a header only if both queues can take the result
        hdr_ready_next = bth_push_ready && aeth_push_ready;
        if (hdr_valid && hdr_ready) begin
          hdr_ready_next = 1'b0;
          pay_ready_next = 1'b1;
          store_hdr      = 1'b1;
          state_next     = st_read_hdr;
        end
      end
      st_read_hdr: begin
        pay_ready_next = 1'b1;
        if (pay_valid && pay_ready) begin
          pay_ready_next = 1'b0;
          store_word     = 1'b1;
          state_next     = st_check;
        end
      end
      st_check: begin
        if (first_last_reg) begin
          state_next = st_idle;
        end else begin
          pay_ready_next = 1'b1;
          state_next     = st_drain;
        end
      end
      default: begin
        // discard the rest of the frame
        pay_ready_next = 1'b1;
        if (pay_valid && pay_ready && pay_last) begin
          pay_ready_next = 1'b0;
          state_next     = st_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      hdr_ready <= 1'b0;
      pay_ready <= 1'b0;
    end else begin
      state     <= state_next;
      hdr_ready <= hdr_ready_next;
      pay_ready <= pay_ready_next;
    end
  end

  always_ff @(posedge clk) begin
    if (store_hdr) begin
      dest_port_reg     <= udp_dest_port;
      length_reg        <= udp_length;
      computed_icrc_reg <= computed_icrc;
    end
    // byte n of the beat sits at bits 8n+7:8n
    // multi-byte fields are big-endian
    if (store_word) begin
      bth_reg.op_code   <= pay_data[7:0];
      bth_reg.p_key     <= {pay_data[23:16], pay_data[31:24]};
      bth_reg.dest_qp   <= {pay_data[47:40], pay_data[55:48], pay_data[63:56]};
      bth_reg.ack_req   <= pay_data[71];
      bth_reg.psn       <= {pay_data[79:72], pay_data[87:80], pay_data[95:88]};
      aeth_reg.syndrome <= pay_data[103:96];
      aeth_reg.msn      <= {pay_data[111:104], pay_data[119:112], pay_data[127:120]};
      received_icrc_reg <= {pay_data[135:128], pay_data[143:136],
                            pay_data[151:144], pay_data[159:152]};
      first_last_reg    <= pay_last;
    end
  end

  // wrong port or opcode wins over a bad icrc
  assign not_ack  = (dest_port_reg != roce_udp_port) || (bth_reg.op_code != op_rc_ack);
  assign bad_icrc = icrc_check_en && (received_icrc_reg != computed_icrc_reg);

  assign bth_push_valid  = (state == st_check) && !not_ack && !bad_icrc;
  assign aeth_push_valid = bth_push_valid;
  assign bth_push_data   = bth_reg;
  assign aeth_push_data  = aeth_reg;

  assign ev_accept    = bth_push_valid;
  assign ev_not_ack   = (state == st_check) && not_ack;
  assign ev_bad_icrc  = (state == st_check) && !not_ack && bad_icrc;
  assign frame_active = (state != st_idle);

  // queue room was checked when the header was taken
  a_push_has_room: assert property (@(posedge clk) disable iff (rst)
    bth_push_valid |-> bth_push_ready && aeth_push_ready);

  a_no_pay_in_idle: assert property (@(posedge clk) disable iff (rst)
    state == st_idle |-> !pay_ready);

  // an accepted ack must have been long enough to hold bth, aeth and icrc
  a_accept_len: assert property (@(posedge clk) disable iff (rst)
    ev_accept |-> length_reg >= min_ack_len);

endmodule

/* roce_rx_top.sv */
`timescale 1ns/1ps

module roce_rx_top #(
  parameter bit icrc_check_en = 1'b1,
  parameter int queue_depth   = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // udp header
  input  logic                 hdr_valid,
  output logic                 hdr_ready,
  input  logic [15:0]          udp_dest_port,
  input  logic [15:0]          udp_length,
  input  roce_ack_pkg::icrc_t  computed_icrc,
  // udp payload
  input  logic                 pay_valid,
  output logic                 pay_ready,
  input  roce_ack_pkg::word_t  pay_data,
  input  logic                 pay_last,
  // decoded headers
  output logic                 bth_valid,
  input  logic                 bth_ready,
  output roce_ack_pkg::bth_t   bth_data,
  output logic                 aeth_valid,
  input  logic                 aeth_ready,
  output roce_ack_pkg::aeth_t  aeth_data,
  // status
  output logic                 busy,
  output roce_ack_pkg::count_t accept_count,
  output roce_ack_pkg::count_t not_ack_count,
  output roce_ack_pkg::count_t bad_icrc_count
);
  import roce_ack_pkg::*;

  logic  bth_push_valid;
  logic  bth_push_ready;
  bth_t  bth_push_data;
  logic  aeth_push_valid;
  logic  aeth_push_ready;
  aeth_t aeth_push_data;
  logic  ev_accept;
  logic  ev_not_ack;
  logic  ev_bad_icrc;
  logic  frame_active;

  roce_frame_parser #(
    .icrc_check_en(icrc_check_en)
  ) roce_frame_parser_inst (
    .clk             (clk),
    .rst             (rst),
    .hdr_valid       (hdr_valid),
    .hdr_ready       (hdr_ready),
    .udp_dest_port   (udp_dest_port),
    .udp_length      (udp_length),
    .computed_icrc   (computed_icrc),
    .pay_valid       (pay_valid),
    .pay_ready       (pay_ready),
    .pay_data        (pay_data),
    .pay_last        (pay_last),
    .bth_push_valid  (bth_push_valid),
    .bth_push_ready  (bth_push_ready),
    .bth_push_data   (bth_push_data),
    .aeth_push_valid (aeth_push_valid),
    .aeth_push_ready (aeth_push_ready),
    .aeth_push_data  (aeth_push_data),
    .ev_accept       (ev_accept),
    .ev_not_ack      (ev_not_ack),
    .ev_bad_icrc     (ev_bad_icrc),
    .frame_active    (frame_active)
  );

  // bth and aeth drain independently
  roce_hdr_queue #(
    .payload_t(bth_t),
    .depth    (queue_depth)
  ) bth_queue_inst (
    .clk        (clk),
    .rst        (rst),
    .push_valid (bth_push_valid),
    .push_ready (bth_push_ready),
    .push_data  (bth_push_data),
    .pop_valid  (bth_valid),
    .pop_ready  (bth_ready),
    .pop_data   (bth_data)
  );

  roce_hdr_queue #(
    .payload_t(aeth_t),
    .depth    (queue_depth)
  ) aeth_queue_inst (
    .clk        (clk),
    .rst        (rst),
    .push_valid (aeth_push_valid),
    .push_ready (aeth_push_ready),
    .push_data  (aeth_push_data),
    .pop_valid  (aeth_valid),
    .pop_ready  (aeth_ready),
    .pop_data   (aeth_data)
  );

  roce_rx_stats roce_rx_stats_inst (
    .clk            (clk),
    .rst            (rst),
    .ev_accept      (ev_accept),
    .ev_not_ack     (ev_not_ack),
    .ev_bad_icrc    (ev_bad_icrc),
    .frame_active   (frame_active),
    .busy           (busy),
    .accept_count   (accept_count),
    .not_ack_count  (not_ack_count),
    .bad_icrc_count (bad_icrc_count)
  );

endmodule

/* roce_rx_tb_ref.svh */
`ifndef ROCE_RX_TB_REF_SVH
`define ROCE_RX_TB_REF_SVH

// decision codes of the reference model
localparam int dec_accept   = 0;
localparam int dec_not_ack  = 1;
localparam int dec_bad_icrc = 2;

// 32-bit lcg, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// one beat of filler from the frame generator
task automatic random_word(output word_t w);
  for (int i = 0; i < 16; i++) begin
    rng_frame = lcg_next(rng_frame);
    w[32*i +: 32] = rng_frame;
  end
endtask

function automatic word_t put_byte(input word_t w, input int n, input logic [7:0] v);
  word_t r;
  r = w;
  r[8*n +: 8] = v;
  return r;
endfunction

// byte n of the beat at bits 8n+7:8n, multi-byte fields big-endian
function automatic word_t build_first_beat(input bth_t b, input aeth_t a, input icrc_t crc,
                                           input word_t fill);
  word_t w;
  w = fill;
  w = put_byte(w, 0, b.op_code);
  w = put_byte(w, 2, b.p_key[15:8]);
  w = put_byte(w, 3, b.p_key[7:0]);
  w = put_byte(w, 5, b.dest_qp[23:16]);
  w = put_byte(w, 6, b.dest_qp[15:8]);
  w = put_byte(w, 7, b.dest_qp[7:0]);
  // ack_req is the top bit of byte 8, the rest stays filler
  w[71] = b.ack_req;
  w = put_byte(w, 9, b.psn[23:16]);
  w = put_byte(w, 10, b.psn[15:8]);
  w = put_byte(w, 11, b.psn[7:0]);
  w = put_byte(w, 12, a.syndrome);
  w = put_byte(w, 13, a.msn[23:16]);
  w = put_byte(w, 14, a.msn[15:8]);
  w = put_byte(w, 15, a.msn[7:0]);
  w = put_byte(w, 16, crc[31:24]);
  w = put_byte(w, 17, crc[23:16]);
  w = put_byte(w, 18, crc[15:8]);
  w = put_byte(w, 19, crc[7:0]);
  return w;
endfunction

// wrong port or opcode is a not-ack even when the icrc is also bad
function automatic int expect_decision(input logic [15:0] port, input logic [7:0] opcode,
                                       input icrc_t rx_crc, input icrc_t calc_crc);
  if ((port != ack_port) || (opcode != ack_opcode)) begin
    return dec_not_ack;
  end
  if (icrc_check && (rx_crc != calc_crc)) begin
    return dec_bad_icrc;
  end
  return dec_accept;
endfunction

task automatic check_bth(input string name, input bth_t got, input bth_t exp);
  check_total++;
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_aeth(input string name, input aeth_t got, input aeth_t exp);
  check_total++;
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input count_t got, input count_t exp);
  check_total++;
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got %h expected %h", name, got, exp);
  end
endtask

`endif

/* roce_rx_tb.sv */
`timescale 1ns/1ps

module roce_rx_tb;
  import roce_ack_pkg::*;

  localparam int          num_frames  = 60;
  localparam int          cycle_limit = 200 * num_frames + 100;
  localparam bit          icrc_check  = 1'b1;
  localparam logic [15:0] ack_port    = 16'd4791;
  localparam logic [7:0]  ack_opcode  = 8'h11;
  localparam logic [31:0] seed        = 32'hfaf88972;

  logic        clk;
  logic        rst;
  logic        hdr_valid;
  logic        hdr_ready;
  logic [15:0] udp_dest_port;
  logic [15:0] udp_length;
  icrc_t       computed_icrc;
  logic        pay_valid;
  logic        pay_ready;
  word_t       pay_data;
  logic        pay_last;
  logic        bth_valid;
  logic        bth_ready;
  bth_t        bth_data;
  logic        aeth_valid;
  logic        aeth_ready;
  aeth_t       aeth_data;
  logic        busy;
  count_t      accept_count;
  count_t      not_ack_count;
  count_t      bad_icrc_count;

  int          err_count;
  int          check_total;
  int          cycle_count;
  int          exp_accept;
  int          exp_not_ack;
  int          exp_bad_icrc;
  bit          drain_out;
  logic [31:0] rng_frame;
  logic [31:0] rng_ready;
  bth_t        exp_bth [$];
  aeth_t       exp_aeth [$];

  `include "roce_rx_tb_ref.svh"

  roce_rx_top roce_rx_top_inst (
    .clk            (clk),
    .rst            (rst),
    .hdr_valid      (hdr_valid),
    .hdr_ready      (hdr_ready),
    .udp_dest_port  (udp_dest_port),
    .udp_length     (udp_length),
    .computed_icrc  (computed_icrc),
    .pay_valid      (pay_valid),
    .pay_ready      (pay_ready),
    .pay_data       (pay_data),
    .pay_last       (pay_last),
    .bth_valid      (bth_valid),
    .bth_ready      (bth_ready),
    .bth_data       (bth_data),
    .aeth_valid     (aeth_valid),
    .aeth_ready     (aeth_ready),
    .aeth_data      (aeth_data),
    .busy           (busy),
    .accept_count   (accept_count),
    .not_ack_count  (not_ack_count),
    .bad_icrc_count (bad_icrc_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // output side back-pressure, low runs of a few cycles
  always @(negedge clk) begin
    rng_ready = lcg_next(rng_ready);
    if (drain_out) begin
      bth_ready  = 1'b1;
      aeth_ready = 1'b1;
    end else begin
      if (rng_ready[31:30] == 2'b00) begin
        bth_ready = !bth_ready;
      end
      if (rng_ready[29:28] == 2'b00) begin
        aeth_ready = !aeth_ready;
      end
    end
  end

  // compare each output transfer with the oldest accepted frame
  always @(posedge clk) begin
    if (!rst) begin
      if (bth_valid && bth_ready) begin
        if (exp_bth.size() == 0) begin
          err_count++;
          $display("bth output transferred while no accepted frame was pending");
        end else begin
          check_bth("bth_data", bth_data, exp_bth.pop_front());
        end
      end
      if (aeth_valid && aeth_ready) begin
        if (exp_aeth.size() == 0) begin
          err_count++;
          $display("aeth output transferred while no accepted frame was pending");
        end else begin
          check_aeth("aeth_data", aeth_data, exp_aeth.pop_front());
        end
      end
    end
  end

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_header(input logic [15:0] port, input logic [15:0] len, input icrc_t crc);
    hdr_valid     = 1'b1;
    udp_dest_port = port;
    udp_length    = len;
    computed_icrc = crc;
    while (!hdr_ready) @(negedge clk);
    @(negedge clk);
    hdr_valid = 1'b0;
  endtask

  task automatic send_beat(input word_t data, input logic last);
    pay_valid = 1'b1;
    pay_data  = data;
    pay_last  = last;
    while (!pay_ready) @(negedge clk);
    @(negedge clk);
    pay_valid = 1'b0;
  endtask

  task automatic send_frame();
    bth_t        b;
    aeth_t       a;
    icrc_t       calc_crc;
    icrc_t       rx_crc;
    logic [15:0] port;
    logic [2:0]  kind;
    int          beats;
    int          decision;
    word_t       w;
    rng_frame = lcg_next(rng_frame);
    kind      = rng_frame[31:29];
    beats     = 1 + int'(rng_frame[28:27]);
    port      = ack_port;
    b.op_code = ack_opcode;
    rng_frame = lcg_next(rng_frame);
    b.p_key   = rng_frame[31:16];
    b.ack_req = rng_frame[15];
    rng_frame = lcg_next(rng_frame);
    b.dest_qp = rng_frame[31:8];
    rng_frame = lcg_next(rng_frame);
    b.psn     = rng_frame[31:8];
    rng_frame = lcg_next(rng_frame);
    a.syndrome = rng_frame[31:24];
    a.msn      = rng_frame[23:0];
    rng_frame = lcg_next(rng_frame);
    calc_crc  = rng_frame;
    rx_crc    = calc_crc;
    rng_frame = lcg_next(rng_frame);
    // kinds 0 to 3 are good acks
    case (kind)
      3'd4: b.op_code = (rng_frame[7:0] == ack_opcode) ? 8'h0a : rng_frame[7:0];
      3'd5: port = (rng_frame[31:16] == ack_port) ? 16'd4792 : rng_frame[31:16];
      3'd6: rx_crc = calc_crc ^ (rng_frame | 32'h1);
      3'd7: begin
        port   = 16'd4790;
        rx_crc = ~calc_crc;
      end
      default: ;
    endcase
    decision = expect_decision(port, b.op_code, rx_crc, calc_crc);
    if (decision == dec_accept) begin
      exp_bth.push_back(b);
      exp_aeth.push_back(a);
      exp_accept++;
    end else if (decision == dec_not_ack) begin
      exp_not_ack++;
    end else begin
      exp_bad_icrc++;
    end
    send_header(port, 16'(8 + 64 * beats), calc_crc);
    random_word(w);
    send_beat(build_first_beat(b, a, rx_crc, w), beats == 1);
    for (int i = 2; i <= beats; i++) begin
      random_word(w);
      send_beat(w, i == beats);
    end
    // busy drops after the decision has reached the counters
    while (busy) @(negedge clk);
    check_count("accept_count", accept_count, count_t'(exp_accept));
    check_count("not_ack_count", not_ack_count, count_t'(exp_not_ack));
    check_count("bad_icrc_count", bad_icrc_count, count_t'(exp_bad_icrc));
  endtask

  initial begin
    rst           = 1'b1;
    hdr_valid     = 1'b0;
    udp_dest_port = '0;
    udp_length    = '0;
    computed_icrc = '0;
    pay_valid     = 1'b0;
    pay_data      = '0;
    pay_last      = 1'b0;
    bth_ready     = 1'b1;
    aeth_ready    = 1'b1;
    err_count     = 0;
    check_total   = 0;
    cycle_count   = 0;
    exp_accept    = 0;
    exp_not_ack   = 0;
    exp_bad_icrc  = 0;
    drain_out     = 1'b0;
    rng_frame     = seed;
    rng_ready     = seed ^ 32'h9e3779b9;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (hdr_ready || pay_ready || bth_valid || aeth_valid || busy) begin
      err_count++;
      $display("a valid, ready or busy output was still high after reset");
    end
    check_count("accept_count", accept_count, '0);
    check_count("not_ack_count", not_ack_count, '0);
    check_count("bad_icrc_count", bad_icrc_count, '0);
    for (int f = 0; f < num_frames; f++) begin
      rng_frame = lcg_next(rng_frame);
      repeat (rng_frame[1:0]) @(negedge clk);
      send_frame();
    end
    // release back-pressure and let both queues empty
    drain_out = 1'b1;
    while ((exp_bth.size() != 0) || (exp_aeth.size() != 0) || busy) @(negedge clk);
    repeat (4) @(negedge clk);
    if (bth_valid || aeth_valid) begin
      err_count++;
      $display("an output stayed valid after every accepted frame was delivered");
    end
    check_count("accept_count", accept_count, count_t'(exp_accept));
    check_count("not_ack_count", not_ack_count, count_t'(exp_not_ack));
    check_count("bad_icrc_count", bad_icrc_count, count_t'(exp_bad_icrc));
    $display("frames %0d, checks %0d, errors %0d", num_frames, check_total, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
roce_ack_pkg.sv
roce_hdr_queue.sv
roce_rx_stats.sv
roce_frame_parser.sv
roce_rx_top.sv
roce_rx_tb.sv

/* Makefile */
TOP = roce_rx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
